/* Bender.yml */
package:
  name: periph_soc

sources:
  - files:
      - periph_pkg.sv
      - hid_decode.sv
      - keyb_fifo.sv
      - char_store.sv
      - sd_ctrl_regs.sv
      - sd_buffer.sv
      - periph_soc.sv
  - target: test
    files:
      - tb_periph_soc.sv

/* char_store.sv */
// Byte-wide character store for screen text on the host bus
module char_store
   import periph_pkg::*;
#(
   parameter int unsigned CHAR_AW = 13
)
(
   input  logic      msoc_clk,
   input  logic      sel_i,
   input  hid_we_t   hid_we_i,
   input  hid_addr_t hid_addr_i,
   input  word_t     hid_wrdata_i,
   output word_t     rdata_o
);

   byte_t              mem [2**CHAR_AW];
   logic [CHAR_AW-1:0] idx;

   assign idx = hid_addr_i[CHAR_AW+1:2];  // One character per word address

   always_ff @(posedge msoc_clk)
   begin
      if (sel_i && (|hid_we_i))
         mem[idx] <= hid_wrdata_i[7:0];
      else if (sel_i)
         rdata_o <= {24'b0, mem[idx]};
   end

endmodule

/* hid_decode.sv */
// Host bus region decoder and registered read-data multiplexer
module hid_decode
   import periph_pkg::*;
(
   input  logic        msoc_clk,
   input  logic        rstn,
   input  logic        hid_en_i,
   input  hid_addr_t   hid_addr_i,
   input  word_t       keyb_rdata_i,
   input  word_t       char_rdata_i,
   input  word_t       sdreg_rdata_i,
   input  word_t       sdbuf_rdata_i,
   output region_sel_t sel_o,
   output word_t       hid_rddata_o
);

   region_t region_q;  // Region of the last access

   always_comb
   begin
      for (int i = 0; i < 4; i++)
         sel_o[i] = hid_en_i & (hid_addr_i[16:15] == region_t'(i));
   end

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
         region_q <= REGION_KEYB;
      else if (hid_en_i)
         region_q <= hid_addr_i[16:15];
   end

   // Peripheral read words arrive registered
   always_comb
   begin
      case (region_q)
         REGION_KEYB:  hid_rddata_o = keyb_rdata_i;
         REGION_CHAR:  hid_rddata_o = char_rdata_i;
         REGION_SDREG: hid_rddata_o = sdreg_rdata_i;
         default:      hid_rddata_o = sdbuf_rdata_i;
      endcase
   end

endmodule

/* keyb_fifo.sv */
// Keyboard code queue, pushed by key strobes and popped by host writes
module keyb_fifo
   import periph_pkg::*;
#(
   parameter int unsigned KEYB_DEPTH = 16
)
(
   input  logic      msoc_clk,
   input  logic      rstn,
   input  logic      sel_i,
   input  hid_we_t   hid_we_i,
   input  logic      key_valid_i,
   input  scancode_t key_scancode_i,
   input  ascii_t    key_ascii_i,
   output word_t     rdata_o
);

   localparam int PTR_W = $clog2(KEYB_DEPTH);
   localparam int CNT_W = $clog2(KEYB_DEPTH + 1);

   logic [14:0]      mem [KEYB_DEPTH];  // {ascii, scancode}
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             empty;
   logic             full;
   logic             push;
   logic             pop;
   logic             rd_en;

   assign empty = (count == '0);
   assign full  = (count == CNT_W'(KEYB_DEPTH));
   assign push  = key_valid_i & ~full;    // Dropped while full
   assign pop   = sel_i & (|hid_we_i) & ~empty;
   assign rd_en = sel_i & ~(|hid_we_i);

   always_ff @(posedge msoc_clk)
   begin
      if (push)
         mem[wr_ptr] <= {key_ascii_i, key_scancode_i};
   end

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         count   <= '0;
         rdata_o <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;  // Wraps at the power-of-two depth
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         if (rd_en)
            rdata_o <= {15'b0, empty, 1'b0, (empty ? 15'b0 : mem[rd_ptr])};
      end
   end

endmodule

/* periph_pkg.sv */
// Peripheral block package with bus widths, region numbers and SD register indices
package periph_pkg;

   typedef logic [31:0] word_t;        // Host data word
   typedef logic [7:0]  byte_t;        // Byte data and LED value
   typedef logic [16:0] hid_addr_t;    // Host byte address
   typedef logic [3:0]  hid_we_t;      // Byte write enables
   typedef logic [1:0]  region_t;      // Region number
   typedef logic [3:0]  region_sel_t;  // One-hot region selects
   typedef logic [7:0]  scancode_t;
   typedef logic [6:0]  ascii_t;
   typedef logic [8:0]  buf_addr_t;    // Sector buffer word address
   typedef logic [4:0]  reg_idx_t;     // Control readback index
   typedef logic [15:0] dip_t;

   // Regions decoded from address bits 16:15
   localparam region_t REGION_KEYB  = 2'd0;
   localparam region_t REGION_CHAR  = 2'd1;
   localparam region_t REGION_SDREG = 2'd2;
   localparam region_t REGION_SDBUF = 2'd3;

   // Writable register indices that double as readback bank offsets
   localparam reg_idx_t IDX_ALIGN     = 5'd0;
   localparam reg_idx_t IDX_CMD_ARG   = 5'd2;
   localparam reg_idx_t IDX_CMD_I     = 5'd3;
   localparam reg_idx_t IDX_SETTING   = 5'd4;
   localparam reg_idx_t IDX_CMD_START = 5'd5;
   localparam reg_idx_t IDX_RESETS    = 5'd6;
   localparam reg_idx_t IDX_BLKCNT    = 5'd7;
   localparam reg_idx_t IDX_BLKSIZE   = 5'd8;
   localparam reg_idx_t IDX_TIMEOUT   = 5'd9;
   localparam reg_idx_t IDX_IRQ_EN    = 5'd11;
   localparam reg_idx_t IDX_LED       = 5'd15;

   // Read-only status indices
   localparam reg_idx_t IDX_STATUS    = 5'd5;
   localparam reg_idx_t IDX_DETECT    = 5'd12;
   localparam reg_idx_t IDX_IRQ_STAT  = 5'd14;
   localparam reg_idx_t IDX_DIP       = 5'd31;
   localparam reg_idx_t IDX_RB_OFS    = 5'd16;  // Written registers read back here

   localparam word_t READ_UNDEF = 32'hDEAD_BEEF;

endpackage

/* periph_soc.sv */
// Peripheral block top with host decode, keyboard queue, text store and SD blocks
module periph_soc
   import periph_pkg::*;
#(
   parameter int unsigned KEYB_DEPTH = 16,
   parameter int unsigned CHAR_AW    = 13
)
(
   input  logic        msoc_clk,
   input  logic        rstn,
   input  logic        hid_en_i,
   input  hid_we_t     hid_we_i,
   input  hid_addr_t   hid_addr_i,
   input  word_t       hid_wrdata_i,
   output word_t       hid_rddata_o,
   input  logic        key_valid_i,
   input  scancode_t   key_scancode_i,
   input  ascii_t      key_ascii_i,
   input  dip_t        from_dip_i,
   output byte_t       to_led_o,
   input  logic        sd_detect_i,
   input  logic        sd_cmd_finish_i,
   input  logic        sd_data_finish_i,
   input  logic [27:0] sd_status_i,
   input  logic        sd_buf_en_i,
   input  logic        sd_buf_we_i,
   input  buf_addr_t   sd_buf_addr_i,
   input  word_t       sd_buf_wdata_i,
   output word_t       sd_buf_rdata_o,
   output logic [1:0]  sd_align_o,
   output word_t       sd_cmd_arg_o,
   output logic [5:0]  sd_cmd_i_o,
   output logic [2:0]  sd_cmd_setting_o,
   output logic [2:0]  sd_data_start_o,
   output logic        sd_cmd_start_o,
   output logic [15:0] sd_blkcnt_o,
   output logic [11:0] sd_blksize_o,
   output word_t       sd_cmd_timeout_o,
   output logic        sd_reset_o,
   output logic        sd_clk_rst_o,
   output logic        sd_data_rst_o,
   output logic        sd_cmd_rst_o,
   output logic        sd_irq_o
);

   region_sel_t sel;
   word_t       keyb_rdata;
   word_t       char_rdata;
   word_t       sdreg_rdata;
   word_t       sdbuf_rdata;

   hid_decode u_decode (
      .msoc_clk      (msoc_clk),
      .rstn          (rstn),
      .hid_en_i      (hid_en_i),
      .hid_addr_i    (hid_addr_i),
      .keyb_rdata_i  (keyb_rdata),
      .char_rdata_i  (char_rdata),
      .sdreg_rdata_i (sdreg_rdata),
      .sdbuf_rdata_i (sdbuf_rdata),
      .sel_o         (sel),
      .hid_rddata_o  (hid_rddata_o)
   );

   keyb_fifo #(.KEYB_DEPTH(KEYB_DEPTH)) u_keyb (
      .msoc_clk       (msoc_clk),
      .rstn           (rstn),
      .sel_i          (sel[REGION_KEYB]),
      .hid_we_i       (hid_we_i),
      .key_valid_i    (key_valid_i),
      .key_scancode_i (key_scancode_i),
      .key_ascii_i    (key_ascii_i),
      .rdata_o        (keyb_rdata)
   );

   char_store #(.CHAR_AW(CHAR_AW)) u_char (
      .msoc_clk     (msoc_clk),
      .sel_i        (sel[REGION_CHAR]),
      .hid_we_i     (hid_we_i),
      .hid_addr_i   (hid_addr_i),
      .hid_wrdata_i (hid_wrdata_i),
      .rdata_o      (char_rdata)
   );

   sd_ctrl_regs u_sdreg (
      .msoc_clk         (msoc_clk),
      .rstn             (rstn),
      .sel_i            (sel[REGION_SDREG]),
      .hid_we_i         (hid_we_i),
      .hid_addr_i       (hid_addr_i),
      .hid_wrdata_i     (hid_wrdata_i),
      .from_dip_i       (from_dip_i),
      .sd_detect_i      (sd_detect_i),
      .sd_cmd_finish_i  (sd_cmd_finish_i),
      .sd_data_finish_i (sd_data_finish_i),
      .sd_status_i      (sd_status_i),
      .rdata_o          (sdreg_rdata),
      .sd_align_o       (sd_align_o),
      .sd_cmd_arg_o     (sd_cmd_arg_o),
      .sd_cmd_i_o       (sd_cmd_i_o),
      .sd_cmd_setting_o (sd_cmd_setting_o),
      .sd_data_start_o  (sd_data_start_o),
      .sd_cmd_start_o   (sd_cmd_start_o),
      .sd_blkcnt_o      (sd_blkcnt_o),
      .sd_blksize_o     (sd_blksize_o),
      .sd_cmd_timeout_o (sd_cmd_timeout_o),
      .sd_reset_o       (sd_reset_o),
      .sd_clk_rst_o     (sd_clk_rst_o),
      .sd_data_rst_o    (sd_data_rst_o),
      .sd_cmd_rst_o     (sd_cmd_rst_o),
      .sd_irq_o         (sd_irq_o),
      .to_led_o         (to_led_o)
   );

   sd_buffer u_sdbuf (
      .msoc_clk       (msoc_clk),
      .sel_i          (sel[REGION_SDBUF]),
      .hid_we_i       (hid_we_i),
      .hid_addr_i     (hid_addr_i),
      .hid_wrdata_i   (hid_wrdata_i),
      .sd_buf_en_i    (sd_buf_en_i),
      .sd_buf_we_i    (sd_buf_we_i),
      .sd_buf_addr_i  (sd_buf_addr_i),
      .sd_buf_wdata_i (sd_buf_wdata_i),
      .rdata_o        (sdbuf_rdata),
      .sd_buf_rdata_o (sd_buf_rdata_o)
   );

endmodule

/* sd_buffer.sv */
// Dual-port SD sector buffer shared by the host and the SD engine
module sd_buffer
   import periph_pkg::*;
(
   input  logic      msoc_clk,
   input  logic      sel_i,
   input  hid_we_t   hid_we_i,
   input  hid_addr_t hid_addr_i,
   input  word_t     hid_wrdata_i,
   input  logic      sd_buf_en_i,
   input  logic      sd_buf_we_i,
   input  buf_addr_t sd_buf_addr_i,
   input  word_t     sd_buf_wdata_i,
   output word_t     rdata_o,
   output word_t     sd_buf_rdata_o
);

   word_t     mem [512];
   buf_addr_t host_addr;

   assign host_addr = hid_addr_i[10:2];

   // Host port with byte lanes and SD engine port with full words
   always_ff @(posedge msoc_clk)
   begin
      if (sel_i)
      begin
         for (int b = 0; b < 4; b++)
            if (hid_we_i[b])
               mem[host_addr][b*8 +: 8] <= hid_wrdata_i[b*8 +: 8];
         if (!(|hid_we_i))
            rdata_o <= mem[host_addr];
      end

      if (sd_buf_en_i)
      begin
         if (sd_buf_we_i)
            mem[sd_buf_addr_i] <= sd_buf_wdata_i;  // Full word from the engine
         sd_buf_rdata_o <= mem[sd_buf_addr_i];
      end
   end

endmodule

/* sd_ctrl_regs.sv */
// SD-card control and status registers with LED, DIP readback and interrupt
module sd_ctrl_regs
   import periph_pkg::*;
(
   input  logic        msoc_clk,
   input  logic        rstn,
   input  logic        sel_i,
   input  hid_we_t     hid_we_i,
   input  hid_addr_t   hid_addr_i,
   input  word_t       hid_wrdata_i,
   input  dip_t        from_dip_i,
   input  logic        sd_detect_i,
   input  logic        sd_cmd_finish_i,
   input  logic        sd_data_finish_i,
   input  logic [27:0] sd_status_i,
   output word_t       rdata_o,
   output logic [1:0]  sd_align_o,
   output word_t       sd_cmd_arg_o,
   output logic [5:0]  sd_cmd_i_o,
   output logic [2:0]  sd_cmd_setting_o,
   output logic [2:0]  sd_data_start_o,
   output logic        sd_cmd_start_o,
   output logic [15:0] sd_blkcnt_o,
   output logic [11:0] sd_blksize_o,
   output word_t       sd_cmd_timeout_o,
   output logic        sd_reset_o,
   output logic        sd_clk_rst_o,
   output logic        sd_data_rst_o,
   output logic        sd_cmd_rst_o,
   output logic        sd_irq_o,
   output byte_t       to_led_o
);

   reg_idx_t   wr_idx;
   reg_idx_t   rd_idx;
   logic       wr_en;
   logic       rd_en;
   logic [3:0] irq_en;
   logic [3:0] irq_stat;  // {removed, inserted, data done, cmd done}
   logic       detect_q;
   dip_t       dip_q;

   assign wr_idx = {1'b0, hid_addr_i[5:2]};
   assign rd_idx = hid_addr_i[6:2];
   assign wr_en  = sel_i & (|hid_we_i) & ~hid_addr_i[14];
   assign rd_en  = sel_i & ~(|hid_we_i);

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         sd_align_o       <= '0;
         sd_cmd_arg_o     <= '0;
         sd_cmd_i_o       <= '0;
         sd_cmd_setting_o <= '0;
         sd_data_start_o  <= '0;
         sd_cmd_start_o   <= 1'b0;
         sd_blkcnt_o      <= '0;
         sd_blksize_o     <= '0;
         sd_cmd_timeout_o <= '0;
         {sd_reset_o, sd_clk_rst_o, sd_data_rst_o, sd_cmd_rst_o} <= 4'b0;
         irq_en           <= '0;
         irq_stat         <= '0;
         sd_irq_o         <= 1'b0;
         to_led_o         <= '0;
         detect_q         <= 1'b0;
         dip_q            <= '0;
         rdata_o          <= '0;
      end
      else
      begin
         irq_stat <= {~sd_detect_i, sd_detect_i, sd_data_finish_i, sd_cmd_finish_i};
         sd_irq_o <= |(irq_en & irq_stat);  // One cycle behind the status
         detect_q <= sd_detect_i;
         dip_q    <= from_dip_i;

         if (wr_en)
            case (wr_idx)
               IDX_ALIGN:     sd_align_o <= hid_wrdata_i[1:0];
               IDX_CMD_ARG:   sd_cmd_arg_o <= hid_wrdata_i;
               IDX_CMD_I:     sd_cmd_i_o <= hid_wrdata_i[5:0];
               IDX_SETTING:   {sd_data_start_o, sd_cmd_setting_o} <= hid_wrdata_i[5:0];
               IDX_CMD_START: sd_cmd_start_o <= hid_wrdata_i[0];
               IDX_RESETS:
                  {sd_reset_o, sd_clk_rst_o, sd_data_rst_o, sd_cmd_rst_o} <= hid_wrdata_i[3:0];
               IDX_BLKCNT:    sd_blkcnt_o <= hid_wrdata_i[15:0];
               IDX_BLKSIZE:   sd_blksize_o <= hid_wrdata_i[11:0];
               IDX_TIMEOUT:   sd_cmd_timeout_o <= hid_wrdata_i;
               IDX_IRQ_EN:    irq_en <= hid_wrdata_i[3:0];
               IDX_LED:       to_led_o <= hid_wrdata_i[7:0];  // Activity display
               default:       ;
            endcase

         if (rd_en)
            case (rd_idx)
               IDX_STATUS:                 rdata_o <= {sd_status_i, 4'b0};
               IDX_DETECT:                 rdata_o <= word_t'(detect_q);
               IDX_IRQ_STAT:               rdata_o <= word_t'(irq_stat);
               IDX_DIP:                    rdata_o <= word_t'(dip_q);  // Boot options
               IDX_RB_OFS + IDX_ALIGN:     rdata_o <= word_t'(sd_align_o);
               IDX_RB_OFS + IDX_CMD_ARG:   rdata_o <= sd_cmd_arg_o;
               IDX_RB_OFS + IDX_CMD_I:     rdata_o <= word_t'(sd_cmd_i_o);
               IDX_RB_OFS + IDX_SETTING:
                  rdata_o <= word_t'({sd_data_start_o, sd_cmd_setting_o});
               IDX_RB_OFS + IDX_CMD_START: rdata_o <= word_t'(sd_cmd_start_o);
               IDX_RB_OFS + IDX_RESETS:
                  rdata_o <= word_t'({sd_reset_o, sd_clk_rst_o, sd_data_rst_o, sd_cmd_rst_o});
               IDX_RB_OFS + IDX_BLKCNT:    rdata_o <= word_t'(sd_blkcnt_o);
               IDX_RB_OFS + IDX_BLKSIZE:   rdata_o <= word_t'(sd_blksize_o);
               IDX_RB_OFS + IDX_TIMEOUT:   rdata_o <= sd_cmd_timeout_o;
               IDX_RB_OFS + IDX_IRQ_EN:    rdata_o <= word_t'(irq_en);
               default:                    rdata_o <= READ_UNDEF;
            endcase
      end
   end

endmodule

/* tb_periph_soc.sv */
// Peripheral block testbench driving random host, keyboard and SD traffic against a model
module tb_periph_soc
   import periph_pkg::*;
;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int unsigned KEYB_DEPTH = 16;
   localparam int unsigned CHAR_AW    = 13;
   localparam int CLK_PERIOD = 20;
   localparam int KEYB_OPS   = 300;
   localparam int CHAR_OPS   = 200;
   localparam int BUF_OPS    = 150;
   localparam int SDW_OPS    = 60;
   localparam int REG_OPS    = 300;
   localparam int IRQ_OPS    = 40;
   localparam int N_OPS = KEYB_OPS + 4 * KEYB_DEPTH + 8 + 64 + CHAR_OPS + 512 + 3 * BUF_OPS
                          + 2 * SDW_OPS + 2 * REG_OPS + 32 + 4 * IRQ_OPS + 4;
   localparam int WATCHDOG_NS = N_OPS * 4 * CLK_PERIOD + 1000;

   logic        msoc_clk = 1'b0;
   logic        rstn;
   logic        hid_en_i;
   hid_we_t     hid_we_i;
   hid_addr_t   hid_addr_i;
   word_t       hid_wrdata_i;
   word_t       hid_rddata_o;
   logic        key_valid_i;
   scancode_t   key_scancode_i;
   ascii_t      key_ascii_i;
   dip_t        from_dip_i;
   byte_t       to_led_o;
   logic        sd_detect_i;
   logic        sd_cmd_finish_i;
   logic        sd_data_finish_i;
   logic [27:0] sd_status_i;
   logic        sd_buf_en_i;
   logic        sd_buf_we_i;
   buf_addr_t   sd_buf_addr_i;
   word_t       sd_buf_wdata_i;
   word_t       sd_buf_rdata_o;
   logic [1:0]  sd_align_o;
   word_t       sd_cmd_arg_o;
   logic [5:0]  sd_cmd_i_o;
   logic [2:0]  sd_cmd_setting_o;
   logic [2:0]  sd_data_start_o;
   logic        sd_cmd_start_o;
   logic [15:0] sd_blkcnt_o;
   logic [11:0] sd_blksize_o;
   word_t       sd_cmd_timeout_o;
   logic        sd_reset_o;
   logic        sd_clk_rst_o;
   logic        sd_data_rst_o;
   logic        sd_cmd_rst_o;
   logic        sd_irq_o;

   logic [31:0] rng_state = 32'h3348_4bff;
   logic [14:0] key_model [$];  // {ascii, scancode} in queue order
   word_t       sdregs [16];    // Written control registers by index
   int          n_checks = 0;
   int          err_word = 0;
   int          err_byte = 0;
   int          err_bit  = 0;

   periph_soc #(.KEYB_DEPTH(KEYB_DEPTH), .CHAR_AW(CHAR_AW)) DUT (.*);

   always #(CLK_PERIOD / 2) msoc_clk = ~msoc_clk;

   function automatic logic [31:0] next_rand();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   function automatic hid_we_t rand_we();
      hid_we_t w;
      w = hid_we_t'(next_rand());
      if (w == '0)
         w = 4'b0001;  // A write needs at least one lane
      return w;
   endfunction

   // Writable bits of each register and none for holes in the map
   function automatic word_t reg_mask(input logic [3:0] n);
      case (n)
         4'd0:        return 32'h0000_0003;
         4'd2, 4'd9:  return 32'hFFFF_FFFF;
         4'd3, 4'd4:  return 32'h0000_003F;
         4'd5:        return 32'h0000_0001;
         4'd6, 4'd11: return 32'h0000_000F;
         4'd7:        return 32'h0000_FFFF;
         4'd8:        return 32'h0000_0FFF;
         4'd15:       return 32'h0000_00FF;
         default:     return 32'h0;
      endcase
   endfunction

   function automatic logic [3:0] irq_status_model();
      return {~sd_detect_i, sd_detect_i, sd_data_finish_i, sd_cmd_finish_i};
   endfunction

   function automatic word_t sdreg_expect(input reg_idx_t idx);
      case (idx)
         5'd5:    return {sd_status_i, 4'b0};
         5'd12:   return word_t'(sd_detect_i);
         5'd14:   return word_t'(irq_status_model());
         5'd31:   return word_t'(from_dip_i);
         default:
         begin
            if (idx[4] && reg_mask(idx[3:0]) != '0)
               return sdregs[idx[3:0]];  // Readback bank
            return READ_UNDEF;
         end
      endcase
   endfunction

   task automatic check_word(input word_t got, input word_t exp, input string what);
      n_checks++;
      if (got !== exp)
      begin
         err_word++;
         $display("** Error @ %0d ns: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_byte(input byte_t got, input byte_t exp, input string what);
      n_checks++;
      if (got !== exp)
      begin
         err_byte++;
         $display("** Error @ %0d ns: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_bit(input logic got, input logic exp, input string what);
      n_checks++;
      if (got !== exp)
      begin
         err_bit++;
         $display("** Error @ %0d ns: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   task automatic bus_write(input hid_addr_t addr, input hid_we_t we, input word_t data);
      @(posedge msoc_clk);
      hid_en_i     <= 1'b1;
      hid_we_i     <= we;
      hid_addr_i   <= addr;
      hid_wrdata_i <= data;
      @(posedge msoc_clk);  // Write lands on this edge
      hid_en_i <= 1'b0;
      hid_we_i <= '0;
   endtask

   task automatic bus_read(input hid_addr_t addr, output word_t data);
      @(posedge msoc_clk);
      hid_en_i   <= 1'b1;
      hid_we_i   <= '0;
      hid_addr_i <= addr;
      @(posedge msoc_clk);
      hid_en_i <= 1'b0;
      @(negedge msoc_clk);
      data = hid_rddata_o;
   endtask

   task automatic sd_write(input buf_addr_t addr, input word_t data);
      @(posedge msoc_clk);
      sd_buf_en_i    <= 1'b1;
      sd_buf_we_i    <= 1'b1;
      sd_buf_addr_i  <= addr;
      sd_buf_wdata_i <= data;
      @(posedge msoc_clk);
      sd_buf_en_i <= 1'b0;
      sd_buf_we_i <= 1'b0;
   endtask

   task automatic sd_read(input buf_addr_t addr, output word_t data);
      @(posedge msoc_clk);
      sd_buf_en_i   <= 1'b1;
      sd_buf_we_i   <= 1'b0;
      sd_buf_addr_i <= addr;
      @(posedge msoc_clk);
      sd_buf_en_i <= 1'b0;
      @(negedge msoc_clk);
      data = sd_buf_rdata_o;
   endtask

   task automatic key_push(input logic [31:0] r);
      @(posedge msoc_clk);
      key_valid_i    <= 1'b1;
      key_scancode_i <= r[7:0];
      key_ascii_i    <= r[14:8];
      @(posedge msoc_clk);
      key_valid_i <= 1'b0;
      if (key_model.size() < KEYB_DEPTH)
         key_model.push_back(r[14:0]);  // Dropped while full
   endtask

   task automatic key_pop(input logic [14:0] ofs);
      bus_write({REGION_KEYB, ofs}, rand_we(), next_rand());
      if (key_model.size() != 0)
         void'(key_model.pop_front());
   endtask

   task automatic keyb_read_check(input logic [14:0] ofs);
      word_t rd;
      word_t exp;
      bus_read({REGION_KEYB, ofs}, rd);
      if (key_model.size() == 0)
         exp = 32'h0001_0000;  // Empty flag alone
      else
         exp = word_t'(key_model[0]);
      check_word(rd, exp, "keyboard word");
   endtask

   // Holds new SD engine levels long enough to reach the interrupt output
   task automatic set_sd_inputs();
      logic [31:0] r;
      logic [31:0] s;
      r = next_rand();
      s = next_rand();
      @(posedge msoc_clk);
      sd_detect_i      <= r[0];
      sd_cmd_finish_i  <= r[1];
      sd_data_finish_i <= r[2];
      from_dip_i       <= r[31:16];
      sd_status_i      <= s[27:0];
      repeat (2) @(posedge msoc_clk);
   endtask

   task automatic check_outputs();
      check_word(word_t'(sd_align_o), sdregs[0], "align");
      check_word(sd_cmd_arg_o, sdregs[2], "command argument");
      check_word(word_t'(sd_cmd_i_o), sdregs[3], "command index");
      check_word(word_t'({sd_data_start_o, sd_cmd_setting_o}), sdregs[4], "setting");
      check_bit(sd_cmd_start_o, sdregs[5][0], "command start");
      check_bit(sd_reset_o, sdregs[6][3], "SD reset");
      check_bit(sd_clk_rst_o, sdregs[6][2], "clock reset");
      check_bit(sd_data_rst_o, sdregs[6][1], "data reset");
      check_bit(sd_cmd_rst_o, sdregs[6][0], "command reset");
      check_word(word_t'(sd_blkcnt_o), sdregs[7], "block count");
      check_word(word_t'(sd_blksize_o), sdregs[8], "block size");
      check_word(sd_cmd_timeout_o, sdregs[9], "timeout");
      check_byte(to_led_o, byte_t'(sdregs[15]), "LED");
   endtask

   task automatic reset_state_check();
      word_t rd;
      @(negedge msoc_clk);
      check_outputs();
      check_bit(sd_irq_o, 1'b0, "interrupt after reset");
      bus_read({REGION_KEYB, 15'h0}, rd);
      check_word(rd, 32'h0001_0000, "keyboard after reset");
   endtask

   task automatic keyb_queue_run();
      logic [31:0] r;
      for (int i = 0; i < KEYB_DEPTH + 4; i++)
         key_push(next_rand());  // Overfill to exercise the drop
      keyb_read_check(15'h0);
      for (int i = 0; i < KEYB_OPS; i++)
      begin
         r = next_rand();
         case (r[1:0])
            2'd0, 2'd1: key_push(next_rand());
            2'd2:       key_pop(r[30:16]);
            default:    keyb_read_check(r[30:16]);
         endcase
      end
      while (key_model.size() != 0)
      begin
         keyb_read_check(15'h7FFF);
         key_pop(15'h0);
      end
      keyb_read_check(15'h1234);
   endtask

   task automatic char_store_run();
      byte_t       cm [64];
      logic [12:0] base;
      logic [31:0] r;
      logic [5:0]  ci;
      word_t       d;
      word_t       rd;
      r = next_rand();
      base = {r[12:6], 6'b0};  // Random window of 64 characters
      for (int i = 0; i < 64; i++)
      begin
         d = next_rand();
         bus_write({REGION_CHAR, base | 13'(i), 2'b00}, rand_we(), d);
         cm[i] = d[7:0];
      end
      for (int i = 0; i < CHAR_OPS; i++)
      begin
         r = next_rand();
         ci = r[13:8];
         if (r[0])
         begin
            d = next_rand();
            bus_write({REGION_CHAR, base | 13'(ci), r[3:2]}, rand_we(), d);
            cm[ci] = d[7:0];
         end
         else
         begin
            bus_read({REGION_CHAR, base | 13'(ci), 2'b00}, rd);
            check_word(rd, word_t'(cm[ci]), "character read");
         end
      end
   endtask

   task automatic sector_buffer_run();
      word_t       bm [512];
      logic [31:0] r;
      buf_addr_t   ba;
      hid_we_t     we;
      word_t       d;
      word_t       rd;
      for (int i = 0; i < 512; i++)
      begin
         d = next_rand();
         sd_write(buf_addr_t'(i), d);
         bm[i] = d;
      end
      for (int i = 0; i < BUF_OPS; i++)
      begin
         r = next_rand();
         ba = r[8:0];
         we = rand_we();
         d = next_rand();
         bus_write({REGION_SDBUF, r[12:9], ba, r[14:13]}, we, d);
         for (int b = 0; b < 4; b++)
            if (we[b])
               bm[ba][b*8 +: 8] = d[b*8 +: 8];
         bus_read({REGION_SDBUF, 4'b0, ba, 2'b00}, rd);
         check_word(rd, bm[ba], "host buffer read");
         sd_read(ba, rd);
         check_word(rd, bm[ba], "SD buffer read");
      end
      for (int i = 0; i < SDW_OPS; i++)
      begin
         r = next_rand();
         ba = r[8:0];
         d = next_rand();
         sd_write(ba, d);
         bm[ba] = d;
         bus_read({REGION_SDBUF, r[12:9], ba, 2'b00}, rd);
         check_word(rd, bm[ba], "host read of SD write");
      end
   endtask

   task automatic ctrl_regs_run();
      logic [31:0] r;
      logic [3:0]  n;
      logic        hi;
      reg_idx_t    idx;
      word_t       d;
      word_t       rd;
      for (int i = 0; i < REG_OPS; i++)
      begin
         r = next_rand();
         case (r[1:0])
            2'd0, 2'd1:
            begin
               n = r[5:2];
               hi = (r[7:6] == 2'b00);  // Bit 14 set blocks the write
               d = next_rand();
               bus_write({REGION_SDREG, hi, r[15:8], n, 2'b00}, rand_we(), d);
               if (!hi)
                  sdregs[n] = d & reg_mask(n);
               @(negedge msoc_clk);
               check_outputs();
            end
            2'd2:
            begin
               idx = r[6:2];
               bus_read({REGION_SDREG, r[15:8], idx, 2'b00}, rd);
               check_word(rd, sdreg_expect(idx), "register readback");
            end
            default: set_sd_inputs();
         endcase
      end
      for (int i = 0; i < 32; i++)
      begin
         bus_read({REGION_SDREG, 8'b0, reg_idx_t'(i), 2'b00}, rd);
         check_word(rd, sdreg_expect(reg_idx_t'(i)), "register sweep");
      end
   endtask

   task automatic irq_run();
      word_t rd;
      word_t d;
      for (int i = 0; i < IRQ_OPS; i++)
      begin
         d = next_rand();
         bus_write({REGION_SDREG, 9'b0, 4'(IDX_IRQ_EN), 2'b00}, 4'hF, d);
         sdregs[11] = d & reg_mask(4'd11);
         set_sd_inputs();
         @(negedge msoc_clk);
         check_bit(sd_irq_o, |(sdregs[11][3:0] & irq_status_model()), "interrupt output");
         bus_read({REGION_SDREG, 8'b0, IDX_IRQ_STAT, 2'b00}, rd);
         check_word(rd, word_t'(irq_status_model()), "interrupt status");
      end
   endtask

   initial
   begin
      #(WATCHDOG_NS);
      $display("Watchdog timeout: the test sequence did not complete in time");
      $display("TEST RESULT: FAIL");
      $finish;
   end

   initial
   begin
      rstn             <= 1'b0;
      hid_en_i         <= 1'b0;
      hid_we_i         <= '0;
      hid_addr_i       <= '0;
      hid_wrdata_i     <= '0;
      key_valid_i      <= 1'b0;
      key_scancode_i   <= '0;
      key_ascii_i      <= '0;
      from_dip_i       <= '0;
      sd_detect_i      <= 1'b0;
      sd_cmd_finish_i  <= 1'b0;
      sd_data_finish_i <= 1'b0;
      sd_status_i      <= '0;
      sd_buf_en_i      <= 1'b0;
      sd_buf_we_i      <= 1'b0;
      sd_buf_addr_i    <= '0;
      sd_buf_wdata_i   <= '0;
      foreach (sdregs[i])
         sdregs[i] = '0;
      repeat (3) @(posedge msoc_clk);
      rstn <= 1'b1;

      reset_state_check();
      keyb_queue_run();
      char_store_run();
      sector_buffer_run();
      ctrl_regs_run();
      irq_run();

      $display("Checks: %0d, word errors: %0d, byte errors: %0d, bit errors: %0d",
               n_checks, err_word, err_byte, err_bit);
      if (err_word + err_byte + err_bit == 0)
         $display("TEST RESULT: PASS");
      else
         $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

/* vlog.f */
periph_pkg.sv
hid_decode.sv
keyb_fifo.sv
char_store.sv
sd_ctrl_regs.sv
sd_buffer.sv
periph_soc.sv
tb_periph_soc.sv
